/* src/udp_gen_pkg.sv */
package udp_gen_pkg;

    // Bus and frame geometry
    localparam int DATA_W         = 64;
    localparam int KEEP_W         = DATA_W / 8;
    localparam int REG_W          = 32;
    localparam int ADDR_W         = 5;
    localparam int BEAT_W         = 5;
    localparam int HDR_BYTES      = 42;           // Ethernet + IPv4 + UDP
    localparam int PAYLOAD_SHORTS = 64;
    localparam int FRAME_BYTES    = HDR_BYTES + 2 * PAYLOAD_SHORTS;

    localparam logic [BEAT_W-1:0] LAST_BEAT     = 5'd21;
    localparam logic [KEEP_W-1:0] LAST_KEEP     = 8'h03;   // 170 = 21*8 + 2
    localparam logic [REG_W-1:0]  DEFAULT_DELAY = 32'd10_000_000;

    // Fixed header fields
    localparam logic [47:0] SRC_MAC       = 48'h00_1A_2B_3C_4D_5E;
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL    = 8'h45;        // IPv4, five words
    localparam logic [7:0]  IP_TOS        = 8'h00;
    localparam logic [15:0] IP_TOTAL_LEN  = 16'd156;
    localparam logic [15:0] IP_IDENT      = 16'h0001;
    localparam logic [15:0] IP_FLAGS_FRAG = 16'h4000;     // Don't fragment
    localparam logic [7:0]  IP_TTL        = 8'hFF;
    localparam logic [7:0]  IP_PROTO_UDP  = 8'h11;
    localparam logic [15:0] UDP_SRC_PORT  = 16'd60133;
    localparam logic [15:0] UDP_DST_PORT  = 16'd60133;
    localparam logic [15:0] UDP_LEN       = 16'd136;
    localparam logic [15:0] UDP_CSUM      = 16'h0000;     // Not computed for UDP

    // Register map
    localparam logic [ADDR_W-1:0] REG_SENT   = 5'h00;
    localparam logic [ADDR_W-1:0] REG_TIMER  = 5'h04;
    localparam logic [ADDR_W-1:0] REG_DELAY  = 5'h08;
    localparam logic [ADDR_W-1:0] REG_MAC_LO = 5'h0C;
    localparam logic [ADDR_W-1:0] REG_MAC_HI = 5'h10;
    localparam logic [ADDR_W-1:0] REG_SRC_IP = 5'h14;
    localparam logic [ADDR_W-1:0] REG_DST_IP = 5'h18;

    typedef enum logic {
        ST_IDLE,
        ST_SEND
    } stream_state_e;

    // MAC byte 0 (first on the wire) sits in dst_mac[47:40]
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [31:0] src_ip;    // First octet in [31:24]
        logic [31:0] dst_ip;
    } frame_cfg_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
    } beat_bytes_t;

    localparam frame_cfg_t DEFAULT_CFG = '{
        dst_mac: 48'hFF_FF_FF_FF_FF_FF,   // Broadcast
        src_ip:  32'hC0_A8_04_63,         // 192.168.4.99
        dst_ip:  32'hC0_A8_04_01          // 192.168.4.1
    };

endpackage

/* src/udp_csr.sv */
`timescale 1ns/1ps

module udp_csr #(
    parameter logic [udp_gen_pkg::REG_W-1:0] reset_delay = udp_gen_pkg::DEFAULT_DELAY
) (
    input  logic                             m00_axis_aclk,
    input  logic                             m00_axis_aresetn,
    input  logic [udp_gen_pkg::ADDR_W-1:0]   s_axi_awaddr,
    input  logic                             s_axi_awvalid,
    output logic                             s_axi_awready,
    input  logic [udp_gen_pkg::REG_W-1:0]    s_axi_wdata,
    input  logic                             s_axi_wvalid,
    output logic                             s_axi_wready,
    output logic [1:0]                       s_axi_bresp,
    output logic                             s_axi_bvalid,
    input  logic                             s_axi_bready,
    input  logic [udp_gen_pkg::ADDR_W-1:0]   s_axi_araddr,
    input  logic                             s_axi_arvalid,
    output logic                             s_axi_arready,
    output logic [udp_gen_pkg::REG_W-1:0]    s_axi_rdata,
    output logic [1:0]                       s_axi_rresp,
    output logic                             s_axi_rvalid,
    input  logic                             s_axi_rready,
    input  logic                             frame_busy,
    input  logic                             frame_done,
    output udp_gen_pkg::frame_cfg_t          cfg,
    output logic                             frame_start
);
    import udp_gen_pkg::*;

    logic [REG_W-1:0] delay_q;
    logic [REG_W-1:0] timer_q;
    logic [REG_W-1:0] sent_q;
    logic [REG_W-1:0] mac_stage_q;   // MAC bytes 2..5, byte 2 in [7:0]
    logic [REG_W-1:0] rd_mux;
    logic             wr_fire;
    logic             rd_fire;
    logic             timer_hit;

    assign s_axi_bresp = 2'b00;
    assign s_axi_rresp = 2'b00;

    assign wr_fire   = s_axi_awready && s_axi_awvalid && s_axi_wvalid;
    assign rd_fire   = s_axi_arready && s_axi_arvalid;
    assign timer_hit = (delay_q != '0) && (timer_q == delay_q);

    // Expiry during a frame is dropped
    assign frame_start = timer_hit && !frame_busy;

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
        end else begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            if (s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid
                    && !s_axi_awready && !s_axi_wready) begin
                s_axi_awready <= 1'b1;
                s_axi_wready  <= 1'b1;
            end
            if (wr_fire)
                s_axi_bvalid <= 1'b1;
            else if (s_axi_bready)
                s_axi_bvalid <= 1'b0;
        end
    end

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            delay_q     <= reset_delay;
            mac_stage_q <= '0;
            cfg         <= DEFAULT_CFG;
        end else if (wr_fire) begin
            case (s_axi_awaddr)
                REG_DELAY:  delay_q <= s_axi_wdata;
                REG_MAC_LO: mac_stage_q <= s_axi_wdata;   // Held until the high word
                REG_MAC_HI: cfg.dst_mac <= {s_axi_wdata[7:0], s_axi_wdata[15:8],
                                            mac_stage_q[7:0], mac_stage_q[15:8],
                                            mac_stage_q[23:16], mac_stage_q[31:24]};
                REG_SRC_IP: cfg.src_ip <= s_axi_wdata;
                REG_DST_IP: cfg.dst_ip <= s_axi_wdata;
                default: begin
                end
            endcase
        end
    end

    // A new delay restarts the interval so a shorter value takes effect at once
    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            timer_q <= '0;
            sent_q  <= '0;
        end else begin
            if (timer_hit || (wr_fire && s_axi_awaddr == REG_DELAY))
                timer_q <= '0;
            else
                timer_q <= timer_q + 1'b1;
            if (frame_done)
                sent_q <= sent_q + 1'b1;
        end
    end

    always_comb begin
        case (s_axi_araddr)
            REG_SENT:   rd_mux = sent_q;
            REG_TIMER:  rd_mux = timer_q;
            REG_DELAY:  rd_mux = delay_q;
            REG_MAC_LO: rd_mux = {cfg.dst_mac[7:0], cfg.dst_mac[15:8],
                                  cfg.dst_mac[23:16], cfg.dst_mac[31:24]};
            REG_MAC_HI: rd_mux = {16'h0000, cfg.dst_mac[39:32], cfg.dst_mac[47:40]};
            REG_SRC_IP: rd_mux = cfg.src_ip;
            REG_DST_IP: rd_mux = cfg.dst_ip;
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            s_axi_arready <= s_axi_arvalid && !s_axi_arready && !s_axi_rvalid;
            if (rd_fire)
                s_axi_rvalid <= 1'b1;
            else if (s_axi_rready)
                s_axi_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge m00_axis_aclk) begin
        if (rd_fire)
            s_axi_rdata <= rd_mux;
    end

endmodule

/* src/ip_header_builder.sv */
`timescale 1ns/1ps

module ip_header_builder (
    input  logic                           m00_axis_aclk,
    input  logic                           m00_axis_aresetn,
    input  logic                           frame_start,
    input  udp_gen_pkg::frame_cfg_t        cfg,
    input  logic [udp_gen_pkg::BEAT_W-1:0] beat_idx,
    output udp_gen_pkg::beat_bytes_t       hdr
);
    import udp_gen_pkg::*;

    frame_cfg_t               cfg_q;      // Frozen for the whole frame
    logic [19:0]              sum_raw;
    logic [16:0]              sum_fold1;
    logic [15:0]              sum_fold2;
    logic [15:0]              ip_csum;
    logic [HDR_BYTES*8-1:0]   hdr_vec;    // Byte 0 in the top bits

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn)
            cfg_q <= DEFAULT_CFG;
        else if (frame_start)
            cfg_q <= cfg;
    end

    // Ones-complement sum over the ten header words, checksum word taken as zero
    always_comb begin
        sum_raw = {4'h0, IP_VER_IHL, IP_TOS}
                + {4'h0, IP_TOTAL_LEN}
                + {4'h0, IP_IDENT}
                + {4'h0, IP_FLAGS_FRAG}
                + {4'h0, IP_TTL, IP_PROTO_UDP}
                + {4'h0, cfg_q.src_ip[31:16]}
                + {4'h0, cfg_q.src_ip[15:0]}
                + {4'h0, cfg_q.dst_ip[31:16]}
                + {4'h0, cfg_q.dst_ip[15:0]};
        sum_fold1 = {1'b0, sum_raw[15:0]} + {13'd0, sum_raw[19:16]};
        sum_fold2 = sum_fold1[15:0] + {15'd0, sum_fold1[16]};   // Second carry fold
        ip_csum   = ~sum_fold2;
    end

    assign hdr_vec = {
        cfg_q.dst_mac,
        SRC_MAC,
        ETH_TYPE_IPV4,
        IP_VER_IHL,
        IP_TOS,
        IP_TOTAL_LEN,
        IP_IDENT,
        IP_FLAGS_FRAG,
        IP_TTL,
        IP_PROTO_UDP,
        ip_csum,
        cfg_q.src_ip,
        cfg_q.dst_ip,
        UDP_SRC_PORT,
        UDP_DST_PORT,
        UDP_LEN,
        UDP_CSUM
    };

    // Lane l of beat b carries frame byte 8b+l
    always_comb begin
        int byte_n;
        hdr = '0;
        for (int lane = 0; lane < KEEP_W; lane++) begin
            byte_n = int'(beat_idx) * KEEP_W + lane;
            if (byte_n < HDR_BYTES) begin
                hdr.data[lane*8 +: 8] = hdr_vec[(HDR_BYTES - 1 - byte_n)*8 +: 8];
                hdr.keep[lane]        = 1'b1;
            end
        end
    end

endmodule

/* src/payload_pattern.sv */
`timescale 1ns/1ps

module payload_pattern (
    input  logic [udp_gen_pkg::BEAT_W-1:0] beat_idx,
    output udp_gen_pkg::beat_bytes_t       pay
);
    import udp_gen_pkg::*;

    localparam int SHORT_IDX_W = $clog2(PAYLOAD_SHORTS);

    // Short 2k is k and short 2k+1 is 255-k, each sent low byte first
    always_comb begin
        int                     byte_n;
        int                     pay_n;
        logic [SHORT_IDX_W-1:0] short_idx;
        logic [15:0]            short_val;
        pay = '0;
        for (int lane = 0; lane < KEEP_W; lane++) begin
            byte_n    = int'(beat_idx) * KEEP_W + lane;
            pay_n     = byte_n - HDR_BYTES;
            short_idx = pay_n[SHORT_IDX_W:1];
            if (short_idx[0])
                short_val = 16'd255 - 16'(short_idx[SHORT_IDX_W-1:1]);
            else
                short_val = 16'(short_idx[SHORT_IDX_W-1:1]);
            if (byte_n >= HDR_BYTES && byte_n < FRAME_BYTES) begin
                pay.data[lane*8 +: 8] = pay_n[0] ? short_val[15:8] : short_val[7:0];
                pay.keep[lane]        = 1'b1;
            end
        end
    end

endmodule

/* src/frame_streamer.sv */
`timescale 1ns/1ps

module frame_streamer (
    input  logic                           m00_axis_aclk,
    input  logic                           m00_axis_aresetn,
    input  logic                           frame_start,
    input  udp_gen_pkg::beat_bytes_t       hdr,
    input  udp_gen_pkg::beat_bytes_t       pay,
    output logic [udp_gen_pkg::BEAT_W-1:0] beat_idx,
    output logic                           frame_busy,
    output logic                           frame_done,
    output logic                           m00_axis_tvalid,
    output logic [udp_gen_pkg::DATA_W-1:0] m00_axis_tdata,
    output logic [udp_gen_pkg::KEEP_W-1:0] m00_axis_tkeep,
    output logic                           m00_axis_tlast,
    input  logic                           m00_axis_tready
);
    import udp_gen_pkg::*;

    stream_state_e state;
    logic          beat_accept;
    logic          last_beat;

    assign beat_accept = (state == ST_SEND) && m00_axis_tready;
    assign last_beat   = (beat_idx == LAST_BEAT);

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            state      <= ST_IDLE;
            beat_idx   <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= beat_accept && last_beat;
            case (state)
                ST_IDLE: begin
                    beat_idx <= '0;
                    if (frame_start)
                        state <= ST_SEND;
                end
                ST_SEND: begin
                    if (beat_accept) begin
                        if (last_beat) begin
                            state    <= ST_IDLE;
                            beat_idx <= '0;
                        end else begin
                            beat_idx <= beat_idx + 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign frame_busy      = (state == ST_SEND);
    assign m00_axis_tvalid = (state == ST_SEND);
    assign m00_axis_tlast  = m00_axis_tvalid && last_beat;
    assign m00_axis_tkeep  = hdr.keep | pay.keep;

    // Header lanes win where the two sources meet in beat 5
    always_comb begin
        m00_axis_tdata = '0;
        for (int lane = 0; lane < KEEP_W; lane++) begin
            if (hdr.keep[lane])
                m00_axis_tdata[lane*8 +: 8] = hdr.data[lane*8 +: 8];
            else if (pay.keep[lane])
                m00_axis_tdata[lane*8 +: 8] = pay.data[lane*8 +: 8];
        end
    end

endmodule

/* src/udp_stream_gen.sv */
`timescale 1ns/1ps

module udp_stream_gen (
    input  logic                           m00_axis_aclk,
    input  logic                           m00_axis_aresetn,
    input  logic [udp_gen_pkg::ADDR_W-1:0] s_axi_awaddr,
    input  logic                           s_axi_awvalid,
    output logic                           s_axi_awready,
    input  logic [udp_gen_pkg::REG_W-1:0]  s_axi_wdata,
    input  logic                           s_axi_wvalid,
    output logic                           s_axi_wready,
    output logic [1:0]                     s_axi_bresp,
    output logic                           s_axi_bvalid,
    input  logic                           s_axi_bready,
    input  logic [udp_gen_pkg::ADDR_W-1:0] s_axi_araddr,
    input  logic                           s_axi_arvalid,
    output logic                           s_axi_arready,
    output logic [udp_gen_pkg::REG_W-1:0]  s_axi_rdata,
    output logic [1:0]                     s_axi_rresp,
    output logic                           s_axi_rvalid,
    input  logic                           s_axi_rready,
    output logic                           m00_axis_tvalid,
    output logic [udp_gen_pkg::DATA_W-1:0] m00_axis_tdata,
    output logic [udp_gen_pkg::KEEP_W-1:0] m00_axis_tkeep,
    output logic                           m00_axis_tlast,
    input  logic                           m00_axis_tready
);
    import udp_gen_pkg::*;

    frame_cfg_t        cfg;
    beat_bytes_t       hdr;
    beat_bytes_t       pay;
    logic [BEAT_W-1:0] beat_idx;
    logic              frame_start;
    logic              frame_busy;
    logic              frame_done;

    udp_csr #(
        .reset_delay (DEFAULT_DELAY)
    ) u_udp_csr (
        .m00_axis_aclk    (m00_axis_aclk),
        .m00_axis_aresetn (m00_axis_aresetn),
        .s_axi_awaddr     (s_axi_awaddr),
        .s_axi_awvalid    (s_axi_awvalid),
        .s_axi_awready    (s_axi_awready),
        .s_axi_wdata      (s_axi_wdata),
        .s_axi_wvalid     (s_axi_wvalid),
        .s_axi_wready     (s_axi_wready),
        .s_axi_bresp      (s_axi_bresp),
        .s_axi_bvalid     (s_axi_bvalid),
        .s_axi_bready     (s_axi_bready),
        .s_axi_araddr     (s_axi_araddr),
        .s_axi_arvalid    (s_axi_arvalid),
        .s_axi_arready    (s_axi_arready),
        .s_axi_rdata      (s_axi_rdata),
        .s_axi_rresp      (s_axi_rresp),
        .s_axi_rvalid     (s_axi_rvalid),
        .s_axi_rready     (s_axi_rready),
        .frame_busy       (frame_busy),
        .frame_done       (frame_done),
        .cfg              (cfg),
        .frame_start      (frame_start)
    );

    ip_header_builder u_ip_header_builder (
        .m00_axis_aclk    (m00_axis_aclk),
        .m00_axis_aresetn (m00_axis_aresetn),
        .frame_start      (frame_start),
        .cfg              (cfg),
        .beat_idx         (beat_idx),
        .hdr              (hdr)
    );

    payload_pattern u_payload_pattern (
        .beat_idx (beat_idx),
        .pay      (pay)
    );

    frame_streamer u_frame_streamer (
        .m00_axis_aclk    (m00_axis_aclk),
        .m00_axis_aresetn (m00_axis_aresetn),
        .frame_start      (frame_start),
        .hdr              (hdr),
        .pay              (pay),
        .beat_idx         (beat_idx),
        .frame_busy       (frame_busy),
        .frame_done       (frame_done),
        .m00_axis_tvalid  (m00_axis_tvalid),
        .m00_axis_tdata   (m00_axis_tdata),
        .m00_axis_tkeep   (m00_axis_tkeep),
        .m00_axis_tlast   (m00_axis_tlast),
        .m00_axis_tready  (m00_axis_tready)
    );

endmodule

/* bench/udp_stream_gen_asserts.sv */
`timescale 1ns/1ps

module udp_stream_gen_asserts (
    input logic                           m00_axis_aclk,
    input logic                           m00_axis_aresetn,
    input logic                           m00_axis_tvalid,
    input logic [udp_gen_pkg::DATA_W-1:0] m00_axis_tdata,
    input logic [udp_gen_pkg::KEEP_W-1:0] m00_axis_tkeep,
    input logic                           m00_axis_tlast,
    input logic                           m00_axis_tready
);
    import udp_gen_pkg::*;

    int fail_count = 0;

    // Beat contents frozen while the sink stalls
    stall_hold: assert property (@(posedge m00_axis_aclk) disable iff (!m00_axis_aresetn)
        m00_axis_tvalid && !m00_axis_tready |=>
            $stable(m00_axis_tdata) && $stable(m00_axis_tkeep) && $stable(m00_axis_tlast))
    else begin
        fail_count++;
        $error("tdata, tkeep or tlast changed while stalled");
    end

    valid_hold: assert property (@(posedge m00_axis_aclk) disable iff (!m00_axis_aresetn)
        m00_axis_tvalid && !m00_axis_tready |=> m00_axis_tvalid)
    else begin
        fail_count++;
        $error("tvalid dropped without an accepted beat");
    end

    last_mask: assert property (@(posedge m00_axis_aclk) disable iff (!m00_axis_aresetn)
        m00_axis_tlast |-> m00_axis_tkeep == LAST_KEEP)
    else begin
        fail_count++;
        $error("tlast with a byte mask other than the last-beat mask");
    end

    reset_quiet: assert property (@(posedge m00_axis_aclk)
        !m00_axis_aresetn |-> !m00_axis_tvalid)
    else begin
        fail_count++;
        $error("tvalid high during reset");
    end

endmodule

/* bench/udp_stream_gen_tb.sv */
`timescale 1ns/1ps

module udp_stream_gen_tb;
    import udp_gen_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int FRAME_DELAY  = 300;
    localparam int LONG_DELAY   = 100_000;   // Far beyond any register sequence
    localparam int NUM_FRAMES   = 10;        // Frames over all tests, with margin
    // Worst case per frame: one interval plus 22 beats at a quarter of full rate
    localparam int WORST_FRAME_NS = (FRAME_DELAY + 1 + 4 * (int'(LAST_BEAT) + 1)) * CLK_PERIOD;
    localparam longint WATCHDOG_NS = 64'd25 * WORST_FRAME_NS * NUM_FRAMES;

    logic                m00_axis_aclk;
    logic                m00_axis_aresetn;
    logic [ADDR_W-1:0]   s_axi_awaddr;
    logic                s_axi_awvalid;
    logic                s_axi_awready;
    logic [REG_W-1:0]    s_axi_wdata;
    logic                s_axi_wvalid;
    logic                s_axi_wready;
    logic [1:0]          s_axi_bresp;
    logic                s_axi_bvalid;
    logic                s_axi_bready;
    logic [ADDR_W-1:0]   s_axi_araddr;
    logic                s_axi_arvalid;
    logic                s_axi_arready;
    logic [REG_W-1:0]    s_axi_rdata;
    logic [1:0]          s_axi_rresp;
    logic                s_axi_rvalid;
    logic                s_axi_rready;
    logic                m00_axis_tvalid;
    logic [DATA_W-1:0]   m00_axis_tdata;
    logic [KEEP_W-1:0]   m00_axis_tkeep;
    logic                m00_axis_tlast;
    logic                m00_axis_tready;

    logic [31:0] lfsr_state = 32'h2eac_2269;

    // Reference model of the configuration, MAC byte 0 goes first on the wire
    logic [7:0]  mdl_mac [6];
    logic [7:0]  mdl_stage [4];    // Bytes 2..5 waiting for the high word
    logic [31:0] mdl_src_ip;
    logic [31:0] mdl_dst_ip;
    logic [7:0]  exp_frame [FRAME_BYTES];
    int          put_pos;

    int err_count   = 0;
    int check_count = 0;
    int last_errs   = 0;
    int beat_n      = 0;
    int frames_seen = 0;
    bit tvalid_seen = 1'b0;

    udp_stream_gen u_udp_stream_gen (.*);

    bind frame_streamer udp_stream_gen_asserts u_stream_asserts (
        .m00_axis_aclk    (m00_axis_aclk),
        .m00_axis_aresetn (m00_axis_aresetn),
        .m00_axis_tvalid  (m00_axis_tvalid),
        .m00_axis_tdata   (m00_axis_tdata),
        .m00_axis_tkeep   (m00_axis_tkeep),
        .m00_axis_tlast   (m00_axis_tlast),
        .m00_axis_tready  (m00_axis_tready)
    );

    initial m00_axis_aclk = 1'b0;
    always #(CLK_PERIOD / 2) m00_axis_aclk = ~m00_axis_aclk;

    // Galois LFSR, one step per random bit
    function automatic logic lfsr_step();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++)
            w = {w[30:0], lfsr_step()};
        return w;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d %s: %0d errors", num, name, err_count - last_errs);
        last_errs = err_count;
    endtask

    task automatic put_bytes(input logic [47:0] value, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin   // Most significant byte first
            exp_frame[put_pos] = value[i*8 +: 8];
            put_pos++;
        end
    endtask

    // Whole expected frame from the model configuration
    task automatic build_expected();
        int          sum;
        logic [15:0] csum;
        logic [15:0] val;
        put_pos = 0;
        for (int k = 0; k < 6; k++)
            put_bytes(48'(mdl_mac[k]), 1);
        put_bytes(SRC_MAC, 6);
        put_bytes(48'(ETH_TYPE_IPV4), 2);
        put_bytes(48'(IP_VER_IHL), 1);
        put_bytes(48'(IP_TOS), 1);
        put_bytes(48'(IP_TOTAL_LEN), 2);
        put_bytes(48'(IP_IDENT), 2);
        put_bytes(48'(IP_FLAGS_FRAG), 2);
        put_bytes(48'(IP_TTL), 1);
        put_bytes(48'(IP_PROTO_UDP), 1);
        put_bytes(48'h0, 2);                  // Checksum, patched below
        put_bytes(48'(mdl_src_ip), 4);
        put_bytes(48'(mdl_dst_ip), 4);
        put_bytes(48'(UDP_SRC_PORT), 2);
        put_bytes(48'(UDP_DST_PORT), 2);
        put_bytes(48'(UDP_LEN), 2);
        put_bytes(48'(UDP_CSUM), 2);
        // IPv4 header spans frame bytes 14 to 33
        sum = 0;
        for (int i = 14; i < 34; i += 2)
            sum += int'({exp_frame[i], exp_frame[i+1]});
        while (sum > 32'hFFFF)
            sum = (sum & 32'hFFFF) + (sum >> 16);
        csum          = ~sum[15:0];
        exp_frame[24] = csum[15:8];
        exp_frame[25] = csum[7:0];
        for (int j = 0; j < PAYLOAD_SHORTS; j++) begin
            val = (j % 2 == 0) ? 16'(j / 2) : 16'(255 - j / 2);
            exp_frame[HDR_BYTES + 2*j]     = val[7:0];    // Low byte first
            exp_frame[HDR_BYTES + 2*j + 1] = val[15:8];
        end
    endtask

    // Stream monitor, sampled mid-cycle where all outputs are settled
    always @(negedge m00_axis_aclk) begin
        if (m00_axis_aresetn && m00_axis_tvalid) begin
            tvalid_seen = 1'b1;
            if (m00_axis_tready) begin
                if (beat_n == 0)
                    build_expected();
                check_value($sformatf("tkeep beat %0d", beat_n), m00_axis_tkeep,
                            beat_n == int'(LAST_BEAT) ? LAST_KEEP : 8'hFF);
                check_value($sformatf("tlast beat %0d", beat_n), m00_axis_tlast,
                            beat_n == int'(LAST_BEAT));
                for (int lane = 0; lane < KEEP_W; lane++) begin
                    if (beat_n * KEEP_W + lane < FRAME_BYTES)
                        check_value($sformatf("tdata beat %0d lane %0d", beat_n, lane),
                                    m00_axis_tdata[lane*8 +: 8],
                                    exp_frame[beat_n * KEEP_W + lane]);
                end
                if (beat_n == int'(LAST_BEAT)) begin
                    beat_n = 0;
                    frames_seen++;
                end else begin
                    beat_n++;
                end
            end
        end
    end

    // Sink readiness, random per cycle
    always @(posedge m00_axis_aclk) begin
        #1;
        m00_axis_tready = lfsr_step();
    end

    task automatic write_register(input logic [ADDR_W-1:0] addr, input logic [REG_W-1:0] data);
        @(posedge m00_axis_aclk);
        #1;
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        s_axi_wdata   = data;
        s_axi_wvalid  = 1'b1;
        s_axi_bready  = 1'b1;
        @(negedge m00_axis_aclk);
        while (!s_axi_awready)
            @(negedge m00_axis_aclk);
        check_value("wready", s_axi_wready, 1'b1);
        @(posedge m00_axis_aclk);
        #1;
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        @(negedge m00_axis_aclk);
        while (!s_axi_bvalid)
            @(negedge m00_axis_aclk);
        check_value("bresp", s_axi_bresp, 2'b00);
        @(posedge m00_axis_aclk);
        #1;
        s_axi_bready = 1'b0;
    endtask

    task automatic read_register(input logic [ADDR_W-1:0] addr, output logic [REG_W-1:0] data);
        @(posedge m00_axis_aclk);
        #1;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        s_axi_rready  = 1'b1;
        @(negedge m00_axis_aclk);
        while (!s_axi_arready)
            @(negedge m00_axis_aclk);
        @(posedge m00_axis_aclk);
        #1;
        s_axi_arvalid = 1'b0;
        @(negedge m00_axis_aclk);
        while (!s_axi_rvalid)
            @(negedge m00_axis_aclk);
        data = s_axi_rdata;
        check_value("rresp", s_axi_rresp, 2'b00);
        @(posedge m00_axis_aclk);
        #1;
        s_axi_rready = 1'b0;
    endtask

    task automatic expect_register(input logic [ADDR_W-1:0] addr, input string name,
                                   input logic [REG_W-1:0] exp);
        logic [REG_W-1:0] got;
        read_register(addr, got);
        check_value(name, got, exp);
    endtask

    // Register write that also updates the model
    task automatic write_config(input logic [ADDR_W-1:0] addr, input logic [REG_W-1:0] data);
        write_register(addr, data);
        case (addr)
            REG_MAC_LO: begin
                for (int i = 0; i < 4; i++)
                    mdl_stage[i] = data[i*8 +: 8];
            end
            REG_MAC_HI: begin
                mdl_mac[0] = data[7:0];
                mdl_mac[1] = data[15:8];
                for (int i = 0; i < 4; i++)
                    mdl_mac[2+i] = mdl_stage[i];
            end
            REG_SRC_IP: mdl_src_ip = data;
            REG_DST_IP: mdl_dst_ip = data;
            default: begin
            end
        endcase
    endtask

    task automatic expect_mac_words();
        expect_register(REG_MAC_LO, "REG_MAC_LO",
                        {mdl_mac[5], mdl_mac[4], mdl_mac[3], mdl_mac[2]});
        expect_register(REG_MAC_HI, "REG_MAC_HI", {16'h0000, mdl_mac[1], mdl_mac[0]});
    endtask

    task automatic await_frames(input int n);
        int target;
        target = frames_seen + n;
        while (frames_seen < target)
            @(negedge m00_axis_aclk);
    endtask

    // Stops new frames and lets one in flight finish
    task automatic drain_stream();
        write_config(REG_DELAY, 32'd0);
        @(negedge m00_axis_aclk);
        while (m00_axis_tvalid)
            @(negedge m00_axis_aclk);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout at %0t: the stream or the register port stopped responding", $time);
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [REG_W-1:0] value;
        logic [REG_W-1:0] timer_a;
        logic [REG_W-1:0] timer_b;
        m00_axis_aresetn = 1'b0;
        s_axi_awaddr     = '0;
        s_axi_awvalid    = 1'b0;
        s_axi_wdata      = '0;
        s_axi_wvalid     = 1'b0;
        s_axi_bready     = 1'b0;
        s_axi_araddr     = '0;
        s_axi_arvalid    = 1'b0;
        s_axi_rready     = 1'b0;
        m00_axis_tready  = 1'b0;
        for (int k = 0; k < 6; k++)
            mdl_mac[k] = DEFAULT_CFG.dst_mac[(5-k)*8 +: 8];
        for (int i = 0; i < 4; i++)
            mdl_stage[i] = 8'h00;
        mdl_src_ip = DEFAULT_CFG.src_ip;
        mdl_dst_ip = DEFAULT_CFG.dst_ip;
        repeat (RESET_CYCLES) @(posedge m00_axis_aclk);
        #1;
        m00_axis_aresetn = 1'b1;

        expect_register(REG_DELAY, "REG_DELAY", 32'd10_000_000);
        expect_register(REG_SENT, "REG_SENT", 32'd0);
        expect_register(REG_SRC_IP, "REG_SRC_IP", mdl_src_ip);
        expect_register(REG_DST_IP, "REG_DST_IP", mdl_dst_ip);
        expect_mac_words();
        check_value("tvalid seen before delay change", tvalid_seen, 1'b0);
        report_test(1, "reset values");

        value = random_word() | 32'h0100_0000;   // Long enough that no frame starts
        write_config(REG_DELAY, value);
        expect_register(REG_DELAY, "REG_DELAY", value);
        value = random_word();
        write_config(REG_SRC_IP, value);
        expect_register(REG_SRC_IP, "REG_SRC_IP", value);
        value = random_word();
        write_config(REG_DST_IP, value);
        expect_register(REG_DST_IP, "REG_DST_IP", value);
        write_config(REG_MAC_LO, random_word());
        write_config(REG_MAC_HI, random_word());
        expect_mac_words();
        // Staged only, the frames of test 3 must still carry the old MAC
        write_config(REG_MAC_LO, random_word());
        expect_mac_words();
        report_test(2, "register readback");

        write_config(REG_DELAY, FRAME_DELAY);
        await_frames(5);
        report_test(3, "frame content");

        repeat (3) begin
            drain_stream();
            write_config(REG_SRC_IP, random_word());
            write_config(REG_DST_IP, random_word());
            write_config(REG_MAC_LO, random_word());
            write_config(REG_MAC_HI, random_word());
            write_config(REG_DELAY, FRAME_DELAY);
            await_frames(1);
        end
        report_test(4, "random addresses");

        drain_stream();
        write_config(REG_DELAY, LONG_DELAY);
        expect_register(REG_SENT, "REG_SENT", frames_seen);
        read_register(REG_TIMER, timer_a);
        read_register(REG_TIMER, timer_b);
        check_value("REG_TIMER first read below delay", timer_a < LONG_DELAY, 1'b1);
        check_value("REG_TIMER second read below delay", timer_b < LONG_DELAY, 1'b1);
        check_value("REG_TIMER reads differ", timer_a != timer_b, 1'b1);
        report_test(5, "frame counter and timer");

        check_value("stream assertion failures",
                    u_udp_stream_gen.u_frame_streamer.u_stream_asserts.fail_count, 0);
        $display("Checks: %0d, errors: %0d, frames: %0d", check_count, err_count, frames_seen);
        if (err_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* verilog.f */
src/udp_gen_pkg.sv
src/udp_csr.sv
src/ip_header_builder.sv
src/payload_pattern.sv
src/frame_streamer.sv
src/udp_stream_gen.sv
bench/udp_stream_gen_asserts.sv
bench/udp_stream_gen_tb.sv

/* Makefile */
# Verilator simulation of the UDP stream generator

VERILATOR ?= verilator
TOP       ?= udp_stream_gen_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
